// File: mem_arb.f
logic/mem_arb_pkg.sv
logic/channel_arb.sv
logic/ddr_cmd_stage.sv
logic/ddr_line_store.sv
logic/mem_arb_top.sv
tests/mem_arb_checker.sv
tests/mem_arb_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mem_arb_tb \
    -f mem_arb.f --Mdir "$BUILD_DIR" -o mem_arb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/mem_arb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tests/mem_arb_tb.sv
`timescale 1ns/1ns

module mem_arb_tb
    import mem_arb_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 3000;  // About 100 accesses of 10 cycles, with margin
    localparam int RANDOM_OPS     = 60;
    localparam int WAIT_LIMIT     = 40;    // Edges one access may take before it is given up

    logic        clock;
    logic        reset_n;
    logic        icache_index_valid;
    dbus_index_t icache_index;
    logic        icache_index_ready;
    line_t       icache_read_data;
    logic        icache_operation_done;
    logic        dcache_index_valid;
    dbus_index_t dcache_index;
    line_t       dcache_write_data;
    line_t       dcache_write_mask;
    dbus_op_t    dcache_operation_type;
    logic        dcache_index_ready;
    line_t       dcache_read_data;
    logic        dcache_operation_done;

    logic [31:0] lfsr;
    line_t       model [LINE_COUNT];  // Expected contents of the store
    line_t       icache_last;         // Last completed read data per channel
    line_t       dcache_last;
    int          value_errors;
    int          other_errors;
    int          cycle_count;

    mem_arb_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic line_t random_line();
        line_t v;
        for (int i = 0; i < $bits(line_t); i++) begin
            v[i] = lfsr_step();
        end
        return v;
    endfunction

    function automatic dbus_index_t make_index(input line_num_t ln);
        dbus_index_t idx;
        idx      = random_bits(64);
        idx[9:6] = ln;  // Random upper bits alias onto the same line
        return idx;
    endfunction

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        other_errors++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    // One request on one channel, compared against the model
    task automatic run_access(input logic dchan, input dbus_op_t op, input line_num_t ln,
                              input line_t data, input line_t mask, input logic timed,
                              output time t_ready, output time t_done);
        line_t expected;
        int    edges;
        logic  accepted;
        logic  finished;
        expected  = (op == DBUS_WRITE) ? ((model[ln] & ~mask) | (data & mask)) : model[ln];
        model[ln] = expected;
        accepted  = 1'b0;
        finished  = 1'b0;
        edges     = 0;
        t_ready   = 0;
        t_done    = 0;
        @(posedge clock);
        #1;
        if (dchan) begin
            dcache_index_valid    = 1'b1;
            dcache_index          = make_index(ln);
            dcache_write_data     = data;
            dcache_write_mask     = mask;
            dcache_operation_type = op;
        end else begin
            icache_index_valid = 1'b1;
            icache_index       = make_index(ln);
        end
        while (!finished && edges < WAIT_LIMIT) begin
            @(negedge clock);
            if (dchan ? dcache_index_ready : icache_index_ready) begin
                if (accepted || (timed && edges != 1))
                    note_failure("index_ready pulse came at the wrong cycle");
                accepted = 1'b1;
                t_ready  = $time;
            end
            if (dchan ? dcache_operation_done : icache_operation_done) begin
                finished = 1'b1;
                t_done   = $time;
                if (!accepted)
                    note_failure("operation_done came before index_ready");
                if (timed && edges != DDR_LATENCY + 3)
                    note_failure("operation_done missed the fixed latency");
                if (dchan) begin
                    check_line("dcache_read_data", dcache_read_data, expected);
                    dcache_last = expected;
                end else begin
                    check_line("icache_read_data", icache_read_data, expected);
                    icache_last = expected;
                end
            end else begin
                // Read data must hold until this channel completes again
                if (dchan)
                    check_line("dcache_read_data", dcache_read_data, dcache_last);
                else
                    check_line("icache_read_data", icache_read_data, icache_last);
                edges++;
            end
            if (t_ready == $time) begin
                @(posedge clock);
                #1;
                if (dchan) dcache_index_valid = 1'b0;
                else icache_index_valid = 1'b0;
            end
        end
        if (!finished)
            note_failure("request never completed");
    endtask

    task automatic test_reset_state();
        @(negedge clock);
        check_bit("icache_operation_done", icache_operation_done, 1'b0);
        check_bit("dcache_operation_done", dcache_operation_done, 1'b0);
        check_bit("icache_index_ready", icache_index_ready, 1'b0);
        check_bit("dcache_index_ready", dcache_index_ready, 1'b0);
        check_line("icache_read_data", icache_read_data, '0);
        check_line("dcache_read_data", dcache_read_data, '0);
    endtask

    task automatic test_write_read();
        time tr;
        time td;
        for (int i = 0; i < LINE_COUNT; i++)
            run_access(1'b1, DBUS_WRITE, line_num_t'(i), random_line(), '1, 1'b1, tr, td);
        for (int i = 0; i < LINE_COUNT; i++)
            run_access(1'b1, DBUS_READ, line_num_t'(i), '0, '0, 1'b1, tr, td);
    endtask

    task automatic test_masked_write();
        time   tr;
        time   td;
        line_t data;
        line_t mask;
        data = random_line();
        mask = random_line();
        run_access(1'b1, DBUS_WRITE, 4'd5, data, mask, 1'b1, tr, td);
        run_access(1'b0, DBUS_READ, 4'd5, '0, '0, 1'b1, tr, td);  // Fill sees the merge
    endtask

    task automatic test_priority();
        time d_ready;
        time d_done;
        time i_ready;
        time i_done;
        fork
            run_access(1'b1, DBUS_READ, 4'd3, '0, '0, 1'b1, d_ready, d_done);
            run_access(1'b0, DBUS_READ, 4'd7, '0, '0, 1'b0, i_ready, i_done);
        join
        if (!(d_ready < i_ready && d_done < i_ready))
            note_failure("instruction cache was served before the data cache");
    endtask

    task automatic test_fixed_latency();
        time tr;
        time td;
        run_access(1'b1, DBUS_READ, 4'd0, '0, '0, 1'b1, tr, td);
        run_access(1'b0, DBUS_READ, 4'd15, '0, '0, 1'b1, tr, td);
    endtask

    task automatic test_random_mix();
        time       tr;
        time       td;
        logic      dchan;
        dbus_op_t  op;
        line_num_t ln;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            dchan = lfsr_step();
            op    = (dchan && lfsr_step()) ? DBUS_WRITE : DBUS_READ;  // Fills only read
            ln    = line_num_t'(random_bits(4));
            if (op == DBUS_WRITE)
                run_access(dchan, op, ln, random_line(), random_line(), 1'b1, tr, td);
            else
                run_access(dchan, op, ln, '0, '0, 1'b1, tr, td);
            // The idle channel keeps its last read data
            if (dchan)
                check_line("icache_read_data", icache_read_data, icache_last);
            else
                check_line("dcache_read_data", dcache_read_data, dcache_last);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: run stopped after %0d cycles", cycle_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        lfsr                  = 32'h672b;
        value_errors          = 0;
        other_errors          = 0;
        icache_last           = '0;
        dcache_last           = '0;
        reset_n               = 1'b0;
        icache_index_valid    = 1'b0;
        icache_index          = '0;
        dcache_index_valid    = 1'b0;
        dcache_index          = '0;
        dcache_write_data     = '0;
        dcache_write_mask     = '0;
        dcache_operation_type = DBUS_READ;
        repeat (10) @(posedge clock);
        #1 reset_n = 1'b1;
        test_reset_state();
        test_write_read();
        test_masked_write();
        test_priority();
        test_fixed_latency();
        test_random_mix();
        @(posedge clock);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: tests/mem_arb_checker.sv
`timescale 1ns/1ns

module mem_arb_checker
    import mem_arb_pkg::*;
(
    input logic       clock,
    input logic       reset_n,
    input logic       ddr_chip_enable,
    input logic       ddr_ready,
    input arb_state_t state,
    input logic       icache_index_ready,
    input logic       dcache_index_ready,
    input logic       icache_operation_done,
    input logic       dcache_operation_done
);

    // Accepted request still waiting for its completion
    logic icache_pending;
    logic dcache_pending;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            icache_pending <= 1'b0;
            dcache_pending <= 1'b0;
        end else begin
            if (icache_index_ready) begin
                icache_pending <= 1'b1;
            end else if (icache_operation_done) begin
                icache_pending <= 1'b0;
            end
            if (dcache_index_ready) begin
                dcache_pending <= 1'b1;
            end else if (dcache_operation_done) begin
                dcache_pending <= 1'b0;
            end
        end
    end

    // Chip enable is a single-cycle pulse
    ce_single: assert property (@(posedge clock) disable iff (!reset_n)
        ddr_chip_enable |=> !ddr_chip_enable)
        else $error("chip enable high two cycles in a row");

    ce_when_ready: assert property (@(posedge clock) disable iff (!reset_n)
        ddr_chip_enable |-> ddr_ready)
        else $error("chip enable while the store is busy");

    // Completion only reaches an accepted channel that still holds the grant
    done_dcache: assert property (@(posedge clock) disable iff (!reset_n)
        dcache_operation_done |-> dcache_pending && state == ARB_DBUS)
        else $error("dcache done outside its grant");

    done_icache: assert property (@(posedge clock) disable iff (!reset_n)
        icache_operation_done |-> icache_pending && state == ARB_PC)
        else $error("icache done outside its grant");

    done_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
        !(icache_operation_done && dcache_operation_done))
        else $error("both channels done together");

endmodule

bind mem_arb_top mem_arb_checker u_checker (
    .clock                 (clock),
    .reset_n               (reset_n),
    .ddr_chip_enable       (ddr_chip_enable),
    .ddr_ready             (ddr_ready),
    .state                 (u_arb.state),
    .icache_index_ready    (icache_index_ready),
    .dcache_index_ready    (dcache_index_ready),
    .icache_operation_done (icache_operation_done),
    .dcache_operation_done (dcache_operation_done)
);

// File: logic/mem_arb_top.sv
`timescale 1ns/1ns

module mem_arb_top
    import mem_arb_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,

    // Instruction cache fill channel
    input  logic        icache_index_valid,
    input  dbus_index_t icache_index,
    output logic        icache_index_ready,
    output line_t       icache_read_data,
    output logic        icache_operation_done,

    // Data cache channel
    input  logic        dcache_index_valid,
    input  dbus_index_t dcache_index,
    input  line_t       dcache_write_data,
    input  line_t       dcache_write_mask,
    input  dbus_op_t    dcache_operation_type,
    output logic        dcache_index_ready,
    output line_t       dcache_read_data,
    output logic        dcache_operation_done
);

    // Arbiter to command stage
    logic        ddr_chip_enable;
    dbus_index_t ddr_index;
    logic        ddr_write_enable;
    line_t       ddr_write_data;
    line_t       ddr_write_mask;

    // Command stage to store
    logic        cmd_valid;
    line_num_t   cmd_line;
    logic        cmd_write;
    line_t       cmd_data;
    line_t       cmd_mask;

    // Store back to arbiter
    logic        ddr_ready;
    logic        ddr_operation_done;
    line_t       ddr_read_data;

    channel_arb u_arb (
        .clock                 (clock),
        .reset_n               (reset_n),
        .icache_index_valid    (icache_index_valid),
        .icache_index          (icache_index),
        .icache_index_ready    (icache_index_ready),
        .icache_read_data      (icache_read_data),
        .icache_operation_done (icache_operation_done),
        .dcache_index_valid    (dcache_index_valid),
        .dcache_index          (dcache_index),
        .dcache_write_data     (dcache_write_data),
        .dcache_write_mask     (dcache_write_mask),
        .dcache_operation_type (dcache_operation_type),
        .dcache_index_ready    (dcache_index_ready),
        .dcache_read_data      (dcache_read_data),
        .dcache_operation_done (dcache_operation_done),
        .ddr_chip_enable       (ddr_chip_enable),
        .ddr_index             (ddr_index),
        .ddr_write_enable      (ddr_write_enable),
        .ddr_write_data        (ddr_write_data),
        .ddr_write_mask        (ddr_write_mask),
        .ddr_read_data         (ddr_read_data),
        .ddr_operation_done    (ddr_operation_done),
        .ddr_ready             (ddr_ready)
    );

    ddr_cmd_stage u_cmd (
        .clock            (clock),
        .reset_n          (reset_n),
        .ddr_chip_enable  (ddr_chip_enable),
        .ddr_index        (ddr_index),
        .ddr_write_enable (ddr_write_enable),
        .ddr_write_data   (ddr_write_data),
        .ddr_write_mask   (ddr_write_mask),
        .cmd_valid        (cmd_valid),
        .cmd_line         (cmd_line),
        .cmd_write        (cmd_write),
        .cmd_data         (cmd_data),
        .cmd_mask         (cmd_mask)
    );

    ddr_line_store u_store (
        .clock              (clock),
        .reset_n            (reset_n),
        .cmd_valid          (cmd_valid),
        .cmd_line           (cmd_line),
        .cmd_write          (cmd_write),
        .cmd_data           (cmd_data),
        .cmd_mask           (cmd_mask),
        .ddr_ready          (ddr_ready),
        .ddr_operation_done (ddr_operation_done),
        .ddr_read_data      (ddr_read_data)
    );

endmodule

// File: logic/ddr_line_store.sv
`timescale 1ns/1ns

module ddr_line_store
    import mem_arb_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,

    // Command from the command stage
    input  logic      cmd_valid,
    input  line_num_t cmd_line,
    input  logic      cmd_write,
    input  line_t     cmd_data,
    input  line_t     cmd_mask,

    // Status and data back to the arbiter
    output logic      ddr_ready,
    output logic      ddr_operation_done,
    output line_t     ddr_read_data
);

    line_t      mem [LINE_COUNT];

    logic       busy;
    lat_count_t count;
    logic       finish;       // Last busy cycle of an access

    // Access in flight
    line_num_t  acc_line;
    logic       acc_write;
    line_t      acc_data;
    line_t      acc_mask;
    line_t      merged;

    assign ddr_ready = ~busy;
    assign finish    = busy && (count == '0);

    // Masked bits take the new data, the rest keep the stored line
    assign merged = (mem[acc_line] & ~acc_mask) | (acc_data & acc_mask);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy               <= 1'b0;
            count              <= '0;
            ddr_operation_done <= 1'b0;
        end else begin
            ddr_operation_done <= 1'b0;
            if (!busy && cmd_valid) begin
                busy  <= 1'b1;
                count <= lat_count_t'(DDR_LATENCY - 1);
            end else if (finish) begin
                busy               <= 1'b0;
                ddr_operation_done <= 1'b1;   // Lands DDR_LATENCY edges after capture
            end else if (busy) begin
                count <= count - 1'b1;
            end
        end
    end

    // Capture the command fields when the access starts
    always_ff @(posedge clock) begin
        if (!busy && cmd_valid) begin
            acc_line  <= cmd_line;
            acc_write <= cmd_write;
            acc_data  <= cmd_data;
            acc_mask  <= cmd_mask;
        end
    end

    // Write lands and read data is produced on the last busy cycle
    always_ff @(posedge clock) begin
        if (finish) begin
            if (acc_write) begin
                mem[acc_line] <= merged;
                ddr_read_data <= merged;   // Write returns the merged line
            end else begin
                ddr_read_data <= mem[acc_line];
            end
        end
    end

endmodule

// File: logic/ddr_cmd_stage.sv
`timescale 1ns/1ns

module ddr_cmd_stage
    import mem_arb_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,

    // Granted request from the arbiter
    input  logic        ddr_chip_enable,
    input  dbus_index_t ddr_index,
    input  logic        ddr_write_enable,
    input  line_t       ddr_write_data,
    input  line_t       ddr_write_mask,

    // Decoded command toward the line store
    output logic        cmd_valid,
    output line_num_t   cmd_line,
    output logic        cmd_write,
    output line_t       cmd_data,
    output line_t       cmd_mask
);

    line_num_t index_line;

    // Line number sits just above the byte offset
    // Bits above it are ignored, so addresses alias onto the 16 lines
    assign index_line = ddr_index[LINE_OFFSET_BITS +: LINE_NUM_BITS];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= ddr_chip_enable;  // One cycle behind the chip enable
        end
    end

    // Command fields only move on the chip enable pulse
    always_ff @(posedge clock) begin
        if (ddr_chip_enable) begin
            cmd_line  <= index_line;
            cmd_write <= ddr_write_enable;
            cmd_data  <= ddr_write_data;
            cmd_mask  <= ddr_write_enable ? ddr_write_mask : '0;
        end
    end

endmodule

// File: logic/channel_arb.sv
`timescale 1ns/1ns

module channel_arb
    import mem_arb_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,

    // Instruction cache fill channel, read only
    input  logic        icache_index_valid,
    input  dbus_index_t icache_index,
    output logic        icache_index_ready,
    output line_t       icache_read_data,
    output logic        icache_operation_done,

    // Data cache channel
    input  logic        dcache_index_valid,
    input  dbus_index_t dcache_index,
    input  line_t       dcache_write_data,
    input  line_t       dcache_write_mask,
    input  dbus_op_t    dcache_operation_type,
    output logic        dcache_index_ready,
    output line_t       dcache_read_data,
    output logic        dcache_operation_done,

    // Toward the memory side
    output logic        ddr_chip_enable,
    output dbus_index_t ddr_index,
    output logic        ddr_write_enable,
    output line_t       ddr_write_data,
    output line_t       ddr_write_mask,
    input  line_t       ddr_read_data,
    input  logic        ddr_operation_done,
    input  logic        ddr_ready
);

    arb_state_t state;
    arb_state_t state_next;

    logic  ce_level;        // High for the whole grant
    logic  ce_latch;        // Grant level one cycle late
    line_t icache_read_hold;
    line_t dcache_read_hold;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Data cache wins ties, nothing is granted while the store is busy
    always_comb begin
        state_next = state;
        case (state)
            ARB_IDLE: begin
                if (dcache_index_valid && ddr_ready) begin
                    state_next = ARB_DBUS;
                end else if (icache_index_valid && ddr_ready) begin
                    state_next = ARB_PC;
                end
            end
            ARB_DBUS, ARB_PC: begin
                if (ddr_operation_done) begin
                    state_next = ARB_IDLE;
                end
            end
            default: state_next = ARB_IDLE;
        endcase
    end

    // Granted channel drives the command fields
    always_comb begin
        ddr_index        = '0;
        ddr_write_enable = 1'b0;
        ddr_write_data   = '0;
        ddr_write_mask   = '0;
        case (state)
            ARB_DBUS: begin
                ddr_index        = dcache_index;
                ddr_write_enable = (dcache_operation_type == DBUS_WRITE);
                ddr_write_data   = dcache_write_data;
                ddr_write_mask   = dcache_write_mask;
            end
            ARB_PC: begin
                ddr_index = icache_index;  // Fills never write
            end
            default: ;
        endcase
    end

    // Turn the grant level into a single-cycle pulse
    assign ce_level = (state != ARB_IDLE);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ce_latch <= 1'b0;
        end else begin
            ce_latch <= ce_level;
        end
    end

    assign ddr_chip_enable = ce_level & ~ce_latch;

    // The command pulse is also the acceptance pulse of the granted cache
    assign dcache_index_ready = ddr_chip_enable & (state == ARB_DBUS);
    assign icache_index_ready = ddr_chip_enable & (state == ARB_PC);

    assign dcache_operation_done = ddr_operation_done & (state == ARB_DBUS);
    assign icache_operation_done = ddr_operation_done & (state == ARB_PC);

    // Read data is kept per channel until its next completion
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            icache_read_hold <= '0;
            dcache_read_hold <= '0;
        end else begin
            if (icache_operation_done) icache_read_hold <= ddr_read_data;
            if (dcache_operation_done) dcache_read_hold <= ddr_read_data;
        end
    end

    // Bypass so the data is already valid in the done cycle
    assign icache_read_data = icache_operation_done ? ddr_read_data : icache_read_hold;
    assign dcache_read_data = dcache_operation_done ? ddr_read_data : dcache_read_hold;

endmodule

// File: logic/mem_arb_pkg.sv
package mem_arb_pkg;

    // Line geometry
    localparam int LINE_BYTES  = 64;
    localparam int LINE_COUNT  = 16;
    localparam int LINE_BITS   = LINE_BYTES * 8;

    // Byte offset bits below the line number in a cache index
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int LINE_NUM_BITS    = $clog2(LINE_COUNT);

    // Cycles the store spends on one access
    localparam int DDR_LATENCY = 4;
    localparam int LAT_BITS    = $clog2(DDR_LATENCY + 1);

    typedef logic [LINE_BITS-1:0]     line_t;         // One cache line, data or mask
    typedef logic [63:0]              dbus_index_t;   // Byte address from a cache
    typedef logic [LINE_NUM_BITS-1:0] line_num_t;     // Line number inside the store
    typedef logic [LAT_BITS-1:0]      lat_count_t;    // Store latency counter

    // Data channel operation
    typedef enum logic {
        DBUS_READ  = 1'b0,
        DBUS_WRITE = 1'b1
    } dbus_op_t;

    // Arbiter grant state
    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_DBUS = 2'b01,
        ARB_PC   = 2'b10
    } arb_state_t;

endpackage
